/* Bender.yml */
package:
  name: tx_output_control

sources:
  - files:
      - verilog/txCtrlPkg.sv
      - verilog/pulseChannel.sv
      - verilog/transducerArray.sv
      - verilog/commandDecoder.sv
      - verilog/instructionSequencer.sv
      - verilog/txOutputControl.sv
  - target: test
    files:
      - tests/programMemory.sv
      - tests/txOutputControlTb.sv

/* list.f */
verilog/txCtrlPkg.sv
verilog/pulseChannel.sv
verilog/transducerArray.sv
verilog/commandDecoder.sv
verilog/instructionSequencer.sv
verilog/txOutputControl.sv
tests/programMemory.sv
tests/txOutputControlTb.sv

/* tests/programMemory.sv */
module programMemory #(
	parameter int addrWidth = 13
) (
	input  logic                 txCLK,
	input  logic [addrWidth-1:0] readAddr,
	output txCtrlPkg::txInstr_t  readData,
	input  logic                 writeEnable,
	input  logic [addrWidth-1:0] writeAddr,
	input  txCtrlPkg::txInstr_t  writeData
);

	txCtrlPkg::txInstr_t mem [2**addrWidth];

	// unwritten words end the program, delay field carries the address
	initial
	begin
		for (int a = 0; a < 2**addrWidth; a++)
			mem[a] = {16'd1 << txCtrlPkg::programEndBit, 16'h0, 32'(a)};
	end

	always @(posedge txCLK)
	begin
		if (writeEnable)
			mem[writeAddr] <= writeData;
		readData <= mem[readAddr];	// data one cycle after the address
	end

endmodule

/* tests/txOutputControlTb.sv */
module txOutputControlTb;

	localparam int addrWidth = 13;
	localparam int period = 20;
	localparam int loops = 3;	// loop body repeats in the last program
	localparam logic [8:0] chargeCycles = 9'd7;
	localparam int selTrig = 0;
	localparam int selLed = 1;
	localparam int selAdc = 2;
	localparam int selAddr = 3;
	localparam int selFall = 4;

	logic                 txCLK;
	logic                 reset;
	logic [7:0]           controlComms;
	logic [7:0]           ledReg;
	logic [7:0]           trigReg;
	logic [7:0]           trigRestLevelReg;
	logic [addrWidth-1:0] setInstructionReadAddr;
	logic [127:0]         phaseDelays;
	logic [7:0]           channelMask;
	logic                 externalTrig;
	logic                 adcTriggerAck;
	txCtrlPkg::txInstr_t  instruction;
	logic [addrWidth-1:0] instructionReadAddr;
	logic [7:0]           transducerOutput;
	logic [7:0]           triggerOutput;
	logic [7:0]           ledOutput;
	logic                 adcTriggerLine;
	logic                 memWrite;
	logic [addrWidth-1:0] memAddr;
	txCtrlPkg::txInstr_t  memData;

	logic [31:0] seed = 32'hf38e;
	logic [7:0]  restLevel = 8'h3c;
	int          checks = 0;
	int          errors = 0;
	int          testStart = 0;
	int          highCount [8];
	longint      riseTime [8];
	longint      fireBase;
	logic [7:0]  fallSeen;
	logic [7:0]  lastOut = '0;
	logic        lastAdc = 1'b0;
	int          adcRises;

	txOutputControl txOutputControl_i (.*);

	programMemory #(
		.addrWidth (addrWidth)
	) programMemory_i (
		.txCLK       (txCLK),
		.readAddr    (instructionReadAddr),
		.readData    (instruction),
		.writeEnable (memWrite),
		.writeAddr   (memAddr),
		.writeData   (memData)
	);

	initial
	begin
		txCLK = 1'b0;
		forever
			#(period / 2) txCLK = ~txCLK;
	end

	// pulse widths, rise times and ADC pulses, taken on the falling edge
	always @(negedge txCLK)
	begin
		for (int i = 0; i < 8; i++)
		begin
			if (transducerOutput[i])
				highCount[i] <= highCount[i] + 1;
			if (transducerOutput[i] && !lastOut[i])
				riseTime[i] <= $time;
			if (!transducerOutput[i] && lastOut[i])
				fallSeen[i] <= 1'b1;
		end
		if (adcTriggerLine && !lastAdc)
			adcRises <= adcRises + 1;
		lastOut <= transducerOutput;
		lastAdc <= adcTriggerLine;
	end

	assert property (@(posedge txCLK) disable iff (reset)
		(transducerOutput & ~channelMask) == '0)
	else
	begin
		errors++;
		$display("[FAIL] %0t: masked channel high, outputs 0x%0h", $time, transducerOutput);
	end

	// ack seen high drops the line on the next edge
	assert property (@(posedge txCLK) disable iff (reset)
		adcTriggerLine && adcTriggerAck |=> !adcTriggerLine)
	else
	begin
		errors++;
		$display("[FAIL] %0t: ADC trigger line still high after acknowledge", $time);
	end

	assert property (@(posedge txCLK) disable iff (reset)
		adcTriggerLine && !adcTriggerAck && controlComms == txCtrlPkg::cmdRunProgram
		|=> adcTriggerLine)
	else
	begin
		errors++;
		$display("[FAIL] %0t: ADC trigger line fell without acknowledge", $time);
	end

	function logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function txCtrlPkg::txInstr_t makeInstr(int opBit, logic [15:0] op, logic [31:0] dly);
		return {16'd1 << opBit, op, dly};
	endfunction

	function logic [15:0] observe(int sel);
		case (sel)
			selTrig: observe = triggerOutput;
			selLed:  observe = ledOutput;
			selAdc:  observe = adcTriggerLine;
			selAddr: observe = instructionReadAddr;
			selFall: observe = fallSeen & channelMask;
			default: observe = '0;
		endcase
	endfunction

	task automatic check(input bit ok, input string what);
		checks++;
		assert (ok)
		else
		begin
			errors++;
			$display("[FAIL] %0t: %s", $time, what);
		end
	endtask

	// polls one output on each falling edge until it matches or the limit runs out
	task automatic waitFor(int sel, logic [15:0] value, int limit, string what);
		int n = 0;
		@(negedge txCLK);
		while (observe(sel) != value && n < limit)
		begin
			@(negedge txCLK);
			n++;
		end
		checks++;
		assert (observe(sel) == value)
		else
		begin
			errors++;
			$display("timed out waiting for %s", what);
		end
	endtask

	task automatic skipCycles(int n);
		repeat (n)
			@(negedge txCLK);
	endtask

	task automatic command(logic [7:0] code);
		@(posedge txCLK);
		controlComms <= code;
	endtask

	task automatic writeWord(logic [addrWidth-1:0] addr, txCtrlPkg::txInstr_t word);
		@(posedge txCLK);
		memWrite <= 1'b1;
		memAddr <= addr;
		memData <= word;
	endtask

	task automatic startProgram(logic [addrWidth-1:0] addr);
		@(posedge txCLK);
		setInstructionReadAddr <= addr;
		controlComms <= txCtrlPkg::cmdLoadProgram;
		skipCycles(3);
		command(txCtrlPkg::cmdRunProgram);
	endtask

	// the fetch must stall on holdAddr until the ADC acknowledges
	task automatic serveAdc(logic [addrWidth-1:0] holdAddr);
		waitFor(selAdc, 16'd1, 100, "the ADC trigger line to rise");
		skipCycles(3);
		check(adcTriggerLine && instructionReadAddr == holdAddr,
			$sformatf("line %0b, address 0x%0h before acknowledge", adcTriggerLine,
			instructionReadAddr));
		@(posedge txCLK);
		adcTriggerAck <= 1'b1;
		waitFor(selAdc, 16'd0, 10, "the ADC trigger line to fall");
		@(posedge txCLK);
		adcTriggerAck <= 1'b0;
	endtask

	task automatic clearRecord();
		@(posedge txCLK);
		for (int i = 0; i < 8; i++)
		begin
			highCount[i] = 0;
			riseTime[i] = 0;
		end
		fallSeen = '0;
		adcRises = 0;
	endtask

	task automatic endTest(string name);
		if (errors == testStart)
			$display("%s: ok", name);
		else
			$display("%s: %0d error(s)", name, errors - testStart);
		testStart = errors;
	endtask

	initial
	begin
		reset = 1'b1;
		controlComms = txCtrlPkg::cmdHardReset;
		ledReg = '0;
		trigReg = '0;
		trigRestLevelReg = '0;
		setInstructionReadAddr = '0;
		phaseDelays = '0;
		channelMask = '0;
		externalTrig = 1'b0;
		adcTriggerAck = 1'b0;
		memWrite = 1'b0;
		memAddr = '0;
		memData = '0;
		repeat (16)
			@(posedge txCLK);
		reset <= 1'b0;

		skipCycles(2);
		check(transducerOutput == '0 && triggerOutput == '0 && ledOutput == '0
			&& !adcTriggerLine && instructionReadAddr == '0, "outputs not 0 after reset");
		endTest("reset state");

		// unwritten words already hold program end
		writeWord(16, makeInstr(txCtrlPkg::setTrigBit, {7'h55, 9'h0}, 5));
		writeWord(17, makeInstr(txCtrlPkg::setLedsBit, 16'h0081, 3));
		writeWord(18, makeInstr(txCtrlPkg::setTrigBit, {7'h0f, 9'h0}, 2));
		writeWord(19, makeInstr(txCtrlPkg::setLedsBit, 16'h007e, 0));
		writeWord(32, makeInstr(txCtrlPkg::triggerRecvBit, 16'h0, 2));
		writeWord(33, makeInstr(txCtrlPkg::setLedsBit, 16'h0011, 0));
		writeWord(48, makeInstr(txCtrlPkg::setChargeTimeBit, 16'(chargeCycles), 0));
		writeWord(49, makeInstr(txCtrlPkg::firePulseBit, 16'h0, 0));
		writeWord(64, makeInstr(txCtrlPkg::loopStartBit, 16'h0, {4'd2, 28'd0}));
		writeWord(65, makeInstr(txCtrlPkg::triggerRecvBit, 16'h0, 1));
		writeWord(66, makeInstr(txCtrlPkg::loopEndBit, 16'd65, {4'd2, 28'(loops)}));
		writeWord(67, makeInstr(txCtrlPkg::waitExternalBit, 16'h0, 0));
		writeWord(68, makeInstr(txCtrlPkg::setLedsBit, 16'h0042, 0));
		@(posedge txCLK);
		memWrite <= 1'b0;

		@(posedge txCLK);
		ledReg <= 8'h5a;
		controlComms <= txCtrlPkg::cmdSetLed;
		waitFor(selLed, 16'h5a, 5, "the manual LEDs");
		@(posedge txCLK);
		trigRestLevelReg <= restLevel;
		controlComms <= txCtrlPkg::cmdSetTrigRest;
		skipCycles(3);
		@(posedge txCLK);
		trigReg <= 8'ha5;
		controlComms <= txCtrlPkg::cmdTestTrig;
		waitFor(selTrig, 8'ha5 ^ restLevel, 5, "the test trigger value");
		check(ledOutput == 8'h5a, $sformatf("LEDs 0x%0h, expected 0x5a", ledOutput));
		command(txCtrlPkg::cmdSoftReset);
		waitFor(selTrig, restLevel, 5, "the triggers to return to rest");
		check(ledOutput == '0, $sformatf("LEDs 0x%0h after soft reset", ledOutput));
		endTest("manual commands");

		startProgram(16);
		waitFor(selTrig, {1'b0, 7'h55} ^ restLevel, 40, "the first program trigger");
		check(ledOutput == '0, $sformatf("LEDs 0x%0h before the first set LEDs", ledOutput));
		waitFor(selLed, 16'h81, 20, "the first program LEDs");
		check(triggerOutput == ({1'b0, 7'h55} ^ restLevel),
			$sformatf("trigger 0x%0h with the first LEDs", triggerOutput));
		waitFor(selTrig, {1'b0, 7'h0f} ^ restLevel, 20, "the second program trigger");
		check(ledOutput == 8'h81, $sformatf("LEDs 0x%0h with the second trigger", ledOutput));
		waitFor(selLed, 16'h7e, 20, "the second program LEDs");
		check(triggerOutput == ({1'b0, 7'h0f} ^ restLevel),
			$sformatf("trigger 0x%0h at program end", triggerOutput));
		endTest("program outputs");

		startProgram(32);
		serveAdc(32);
		waitFor(selLed, 16'h11, 20, "the LEDs after the ADC acknowledge");
		endTest("ADC trigger");

		@(posedge txCLK);
		for (int i = 0; i < 8; i++)
			phaseDelays[i*16 +: 16] <= 16'(nextRandom() >> 27);
		channelMask <= (8'(nextRandom() >> 24) | 8'h01) & 8'h7f;	// some on, some off
		clearRecord();
		startProgram(48);
		waitFor(selFall, channelMask, 300, "all unmasked channels to finish");
		fireBase = riseTime[0] - phaseDelays[15:0] * period;
		for (int i = 0; i < 8; i++)
		begin
			if (channelMask[i])
			begin
				check(highCount[i] == chargeCycles, $sformatf("channel %0d high for %0d cycles",
					i, highCount[i]));
				check(riseTime[i] - phaseDelays[i*16 +: 16] * period == fireBase,
					$sformatf("channel %0d rose at %0t, off its phase delay", i, riseTime[i]));
			end
			else
				check(highCount[i] == 0, $sformatf("masked channel %0d pulsed", i));
		end
		endTest("firing");

		clearRecord();
		startProgram(64);
		repeat (loops)
			serveAdc(65);
		waitFor(selAddr, 16'd67, 30, "the wait instruction");
		skipCycles(10);
		check(instructionReadAddr == 67,
			$sformatf("address 0x%0h without external trigger", instructionReadAddr));
		check(adcRises == loops, $sformatf("%0d ADC pulses, expected %0d", adcRises, loops));
		@(posedge txCLK);
		externalTrig <= 1'b1;
		waitFor(selAddr, 16'd68, 5, "the fetch after the external trigger");
		@(posedge txCLK);
		externalTrig <= 1'b0;
		waitFor(selLed, 16'h42, 10, "the LEDs after the wait");
		endTest("loop and wait");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* verilog/commandDecoder.sv */
module commandDecoder (
	input  logic                  txCLK,
	input  logic                  reset,
	input  logic [7:0]            controlComms,
	input  logic [7:0]            ledReg,
	input  logic [7:0]            trigReg,
	input  logic [7:0]            trigRestLevelReg,
	output txCtrlPkg::manualOut_t ctrl
);

	txCtrlPkg::manualOut_t nextCtrl;

	// everything defaults low each cycle, only the rest level is held
	always_comb
	begin
		nextCtrl = '0;
		nextCtrl.trigRestLevel = ctrl.trigRestLevel;
		case (controlComms)
			txCtrlPkg::cmdHardReset:
			begin
				nextCtrl.safe = 1'b1;
				nextCtrl.trigRestLevel = '0;	// only hard reset forgets it
			end
			txCtrlPkg::cmdLoadProgram:
			begin
				nextCtrl.safe = 1'b1;
				nextCtrl.loadStart = 1'b1;
			end
			txCtrlPkg::cmdSetTrig:
			begin
				nextCtrl.manualTrig = trigReg;
				nextCtrl.manualTrigValid = 1'b1;
			end
			txCtrlPkg::cmdSetTrigRest:
			begin
				// first cycle after run still sees running
				if (!ctrl.running)
					nextCtrl.trigRestLevel = trigRestLevelReg;
			end
			txCtrlPkg::cmdTestTrig:
			begin
				nextCtrl.manualTrig = trigReg ^ ctrl.trigRestLevel;
				nextCtrl.manualTrigValid = 1'b1;
			end
			txCtrlPkg::cmdSetLed:
			begin
				nextCtrl.manualLed = ledReg;
				nextCtrl.manualLedValid = 1'b1;
			end
			txCtrlPkg::cmdRunProgram:
				nextCtrl.running = 1'b1;
			default:
				nextCtrl.safe = 1'b1;	// soft reset and unknown codes
		endcase
	end

	always_ff @(posedge txCLK)
	begin
		if (reset)
			ctrl <= '0;
		else
			ctrl <= nextCtrl;
	end

	// a program must never run with the outputs pinned to safe
	assert property (@(posedge txCLK) disable iff (reset)
		!(ctrl.safe && ctrl.running))
	else
		$error("safe and running both high");

endmodule

/* verilog/instructionSequencer.sv */
module instructionSequencer #(
	parameter int loopSlots = 16,
	parameter int addrWidth = 13
) (
	input  logic                  txCLK,
	input  logic                  reset,
	input  txCtrlPkg::manualOut_t ctrl,
	input  txCtrlPkg::txInstr_t   instruction,
	input  logic [addrWidth-1:0]  setInstructionReadAddr,
	input  logic                  externalTrig,
	input  logic                  adcTriggerAck,
	output logic [addrWidth-1:0]  instructionReadAddr,
	output logic [7:0]            triggerOutput,
	output logic [7:0]            ledOutput,
	output logic                  adcTriggerLine,
	output txCtrlPkg::fireCmd_t   fire
);

	typedef enum logic [2:0] {sIdle, sFetch, sExec, sDelay, sWait, sEnd} seqState_t;

	seqState_t            state;
	logic [addrWidth-1:0] startAddr;
	logic [addrWidth-1:0] pendingAddr;	// address to issue once the delay runs out
	logic [31:0]          delayCnt;
	logic [8:0]           chargeTime;
	logic                 fireStrobe;
	logic [27:0]          loopCount [loopSlots];
	logic [loopSlots-1:0] loopActive;

	logic [15:0] instrType;
	logic [3:0]  loopSlot;
	logic [27:0] loopTarget;
	logic        loopBranch;
	logic        loopCountLoad;
	logic        adcReady;

	assign instrType  = instruction.instrType;
	assign loopSlot   = instruction.delay[31:28];
	assign loopTarget = instruction.delay[27:0];

	// first visit of a loop end means the body already ran once
	assign loopBranch = loopActive[loopSlot] ? (loopCount[loopSlot] < loopTarget)
		: (loopTarget > 28'd1);
	assign loopCountLoad = ctrl.running && state == sExec
		&& instrType[txCtrlPkg::loopEndBit] && loopBranch;

	assign adcReady = !adcTriggerLine || adcTriggerAck;	// next fetch waits on the ADC
	assign fire = '{fire: fireStrobe, chargeTime: chargeTime};

	always_ff @(posedge txCLK)
	begin
		if (loopCountLoad)
			loopCount[loopSlot] <= loopActive[loopSlot] ? loopCount[loopSlot] + 28'd1 : 28'd2;
	end

	always_ff @(posedge txCLK)
	begin
		if (reset)
		begin
			state <= sIdle;
			startAddr <= '0;
			pendingAddr <= '0;
			instructionReadAddr <= '0;
			delayCnt <= '0;
			chargeTime <= txCtrlPkg::defaultChargeTime;
			fireStrobe <= 1'b0;
			loopActive <= '0;
			triggerOutput <= '0;
			ledOutput <= '0;
			adcTriggerLine <= 1'b0;
		end
		else
		begin
			fireStrobe <= 1'b0;
			if (!ctrl.running)
			begin
				// manual side, program state dropped
				state <= sIdle;
				loopActive <= '0;
				adcTriggerLine <= 1'b0;
				if (ctrl.loadStart)
				begin
					startAddr <= setInstructionReadAddr;
					instructionReadAddr <= setInstructionReadAddr;
				end
				if (ctrl.safe)
				begin
					triggerOutput <= ctrl.trigRestLevel;
					ledOutput <= '0;
				end
				else
				begin
					if (ctrl.manualTrigValid)
						triggerOutput <= ctrl.manualTrig;
					if (ctrl.manualLedValid)
						ledOutput <= ctrl.manualLed;
				end
			end
			else
			begin
				if (adcTriggerLine && adcTriggerAck)
					adcTriggerLine <= 1'b0;
				case (state)
					sIdle:
					begin
						instructionReadAddr <= startAddr;
						state <= sFetch;
					end
					sFetch:
						state <= sExec;	// memory answers next cycle
					sExec:
					begin
						pendingAddr <= instructionReadAddr + 1'b1;
						delayCnt <= instruction.delay;
						state <= sDelay;
						if (instrType[txCtrlPkg::setTrigBit])
							triggerOutput <= {1'b0, instruction.operand[15:9]} ^ ctrl.trigRestLevel;
						if (instrType[txCtrlPkg::setLedsBit])
							ledOutput <= instruction.operand[7:0];
						if (instrType[txCtrlPkg::triggerRecvBit])
							adcTriggerLine <= 1'b1;
						if (instrType[txCtrlPkg::firePulseBit])
							fireStrobe <= 1'b1;
						if (instrType[txCtrlPkg::setChargeTimeBit])
							chargeTime <= instruction.operand[8:0];
						if (instrType[txCtrlPkg::loopStartBit])
						begin
							delayCnt <= '0;
							loopActive[loopSlot] <= 1'b0;	// fresh count on entry
						end
						if (instrType[txCtrlPkg::loopEndBit])
						begin
							delayCnt <= '0;
							loopActive[loopSlot] <= loopBranch;
							if (loopBranch)
								pendingAddr <= instruction.operand[addrWidth-1:0];
						end
						if (instrType[txCtrlPkg::waitExternalBit])
							state <= sWait;
						if (instrType[txCtrlPkg::programEndBit])
							state <= sEnd;
					end
					sDelay:
					begin
						if (delayCnt != '0)
							delayCnt <= delayCnt - 1'b1;
						else if (adcReady)
						begin
							instructionReadAddr <= pendingAddr;
							state <= sFetch;
						end
					end
					sWait:
					begin
						if (externalTrig)
						begin
							instructionReadAddr <= pendingAddr;
							state <= sFetch;
						end
					end
					sEnd:
						state <= sEnd;	// outputs hold until the mode changes
					default:
						state <= sIdle;
				endcase
			end
		end
	end

	// program memory contents must carry exactly one opcode bit
	assert property (@(posedge txCLK) disable iff (reset)
		(ctrl.running && state == sExec) |-> $onehot(instrType))
	else
		$error("instruction type not one-hot at 0x%0h", instructionReadAddr);

endmodule

/* verilog/pulseChannel.sv */
module pulseChannel #(
	parameter int delayWidth = 16
) (
	input  logic                  txCLK,
	input  logic                  reset,
	input  logic                  start,
	input  logic [delayWidth-1:0] count,
	input  logic [delayWidth-1:0] phaseDelay,
	input  logic [8:0]            chargeTime,
	output logic                  pulse,
	output logic                  done
);

	logic [8:0] remaining;	// charge cycles still to go

	always_ff @(posedge txCLK)
	begin
		if (reset)
		begin
			pulse <= 1'b0;
			done <= 1'b1;	// idle counts as finished
			remaining <= '0;
		end
		else if (start)
		begin
			pulse <= 1'b0;
			done <= 1'b0;
		end
		else if (pulse)
		begin
			if (remaining == 9'd1)
			begin
				pulse <= 1'b0;
				done <= 1'b1;
			end
			else
				remaining <= remaining - 1'b1;
		end
		else if (!done && count == phaseDelay)
		begin
			// zero charge time means nothing to drive
			if (chargeTime == '0)
				done <= 1'b1;
			else
			begin
				pulse <= 1'b1;
				remaining <= chargeTime;
			end
		end
	end

endmodule

/* verilog/transducerArray.sv */
module transducerArray #(
	parameter int numChannels = 8,
	parameter int delayWidth  = 16
) (
	input  logic                              txCLK,
	input  logic                              reset,
	input  txCtrlPkg::fireCmd_t               fire,
	input  logic [numChannels*delayWidth-1:0] phaseDelays,
	input  logic [numChannels-1:0]            channelMask,
	input  logic                              safe,
	output logic [numChannels-1:0]            transducerOutput,
	output logic                              txActive
);

	logic [delayWidth-1:0]                   fireCount;	// shared by all channels
	logic [numChannels-1:0][delayWidth-1:0] delays;
	logic [8:0]                              chargeTime;
	logic [numChannels-1:0]                  pulses;
	logic [numChannels-1:0]                  done;
	logic                                    start;

	assign start = fire.fire && !txActive;	// fires during a pulse are dropped
	assign txActive = ~&done;

	always_ff @(posedge txCLK)
	begin
		if (reset)
			fireCount <= '0;
		else if (start)
			fireCount <= '0;
		else if (txActive)
			fireCount <= fireCount + 1'b1;
	end

	// snapshot of the delays and charge time for this shot
	always_ff @(posedge txCLK)
	begin
		if (start)
		begin
			delays <= phaseDelays;
			chargeTime <= fire.chargeTime;
		end
	end

	for (genvar i = 0; i < numChannels; i++)
	begin : channel
		pulseChannel #(
			.delayWidth (delayWidth)
		) pulseChannel_i (
			.txCLK      (txCLK),
			.reset      (reset),
			.start      (start),
			.count      (fireCount),
			.phaseDelay (delays[i]),
			.chargeTime (chargeTime),
			.pulse      (pulses[i]),
			.done       (done[i])
		);
	end

	assign transducerOutput = safe ? '0 : (pulses & channelMask);

	assert property (@(posedge txCLK) disable iff (reset)
		(transducerOutput & ~channelMask) == '0)
	else
		$error("masked channel driven high");

endmodule

/* verilog/txCtrlPkg.sv */
package txCtrlPkg;

	// one 64-bit program word: type in the top 16 bits, delay in the low 32
	typedef struct packed {
		logic [15:0] instrType;	// one-hot opcode
		logic [15:0] operand;
		logic [31:0] delay;	// cycles before the next fetch
	} txInstr_t;

	// bit positions inside instrType
	localparam int setTrigBit       = 0;
	localparam int setLedsBit       = 1;
	localparam int triggerRecvBit   = 2;
	localparam int loopStartBit     = 4;
	localparam int loopEndBit       = 5;
	localparam int firePulseBit     = 6;
	localparam int setChargeTimeBit = 8;
	localparam int waitExternalBit  = 10;
	localparam int programEndBit    = 15;

	// control command codes
	localparam logic [7:0] cmdHardReset   = 8'd0;
	localparam logic [7:0] cmdSoftReset   = 8'd1;
	localparam logic [7:0] cmdLoadProgram = 8'd2;
	localparam logic [7:0] cmdSetTrig     = 8'd4;
	localparam logic [7:0] cmdSetTrigRest = 8'd5;
	localparam logic [7:0] cmdTestTrig    = 8'd6;
	localparam logic [7:0] cmdSetLed      = 8'd8;
	localparam logic [7:0] cmdRunProgram  = 8'd128;

	// charge time used until a program sets its own
	localparam logic [8:0] defaultChargeTime = 9'd500;

	// decoded mode and manual values, decoder to sequencer
	typedef struct packed {
		logic       running;
		logic       safe;
		logic       loadStart;
		logic [7:0] manualTrig;
		logic       manualTrigValid;
		logic [7:0] manualLed;
		logic       manualLedValid;
		logic [7:0] trigRestLevel;
	} manualOut_t;

	// fire request, sequencer to transducer array
	typedef struct packed {
		logic       fire;	// single cycle
		logic [8:0] chargeTime;
	} fireCmd_t;

endpackage

/* verilog/txOutputControl.sv */
module txOutputControl #(
	parameter int numChannels = 8,
	parameter int loopSlots   = 16,
	parameter int addrWidth   = 13,
	parameter int delayWidth  = 16
) (
	input  logic                              txCLK,
	input  logic                              reset,
	input  logic [7:0]                        controlComms,
	input  txCtrlPkg::txInstr_t               instruction,
	input  logic [addrWidth-1:0]              setInstructionReadAddr,
	input  logic [numChannels*delayWidth-1:0] phaseDelays,
	input  logic [numChannels-1:0]            channelMask,
	input  logic                              externalTrig,
	input  logic                              adcTriggerAck,
	input  logic [7:0]                        ledReg,
	input  logic [7:0]                        trigReg,
	input  logic [7:0]                        trigRestLevelReg,
	output logic [addrWidth-1:0]              instructionReadAddr,
	output logic [numChannels-1:0]            transducerOutput,
	output logic [7:0]                        triggerOutput,
	output logic [7:0]                        ledOutput,
	output logic                              adcTriggerLine
);

	txCtrlPkg::manualOut_t ctrl;	// mode and manual values
	txCtrlPkg::fireCmd_t   fire;

	commandDecoder commandDecoder_i (
		.txCLK            (txCLK),
		.reset            (reset),
		.controlComms     (controlComms),
		.ledReg           (ledReg),
		.trigReg          (trigReg),
		.trigRestLevelReg (trigRestLevelReg),
		.ctrl             (ctrl)
	);

	instructionSequencer #(
		.loopSlots (loopSlots),
		.addrWidth (addrWidth)
	) instructionSequencer_i (
		.txCLK                  (txCLK),
		.reset                  (reset),
		.ctrl                   (ctrl),
		.instruction            (instruction),
		.setInstructionReadAddr (setInstructionReadAddr),
		.externalTrig           (externalTrig),
		.adcTriggerAck          (adcTriggerAck),
		.instructionReadAddr    (instructionReadAddr),
		.triggerOutput          (triggerOutput),
		.ledOutput              (ledOutput),
		.adcTriggerLine         (adcTriggerLine),
		.fire                   (fire)
	);

	// txActive only matters inside the array for now
	transducerArray #(
		.numChannels (numChannels),
		.delayWidth  (delayWidth)
	) transducerArray_i (
		.txCLK            (txCLK),
		.reset            (reset),
		.fire             (fire),
		.phaseDelays      (phaseDelays),
		.channelMask      (channelMask),
		.safe             (ctrl.safe),
		.transducerOutput (transducerOutput),
		.txActive         ()
	);

endmodule
